// File: include/regbus_params.svh
// Register bus address width, scratch depth and timer window macros
`ifndef REGBUS_PARAMS_SVH
`define REGBUS_PARAMS_SVH

// --------------------
// Address map
// --------------------

// Byte address width of the register port
`define REGBUS_ADDR_BITS 12

// Scratch bank depth in 32-bit words, window starts at 0x000
`define REGBUS_SCRATCH_WORDS 8

// Timer window base, four words long
`define REGBUS_TIMER_BASE 12'h100

// Timer register byte offsets within the window
`define REGBUS_TIMER_CTRL    4'h0
`define REGBUS_TIMER_COMPARE 4'h4
`define REGBUS_TIMER_COUNT   4'h8
`define REGBUS_TIMER_STATUS  4'hC

`endif

// File: verilog/regbus_pkg.sv
// Register bus address, data and slave-select types
`include "regbus_params.svh"

package regbus_pkg;

	// --------------------
	// Register port types
	// --------------------

	// Byte address on the register port
	typedef logic [`REGBUS_ADDR_BITS-1:0] reg_addr_t;

	// One register word, always written whole
	typedef logic [31:0] reg_data_t;

	// Decoder result
	// sel_none means the address hits no window and ends with an error
	typedef enum logic [1:0] {
		sel_none,
		sel_scratch,
		sel_timer
	} reg_sel_e;

endpackage

// File: verilog/reg_port_if.sv
// Register port interface with master, slave and target modports
`timescale 1ns/1ps

interface reg_port_if (
	input logic CLK
);
	// Write and read strobes, one-cycle pulses, never together
	logic we;
	logic re;

	// Shared by both directions
	regbus_pkg::reg_addr_t addr;
	regbus_pkg::reg_data_t wdata;

	// Registered by the target on the re edge, valid one cycle later
	regbus_pkg::reg_data_t rdata;

	// Combinational from addr, set when no window matches
	logic err;

	// Bus-facing side, also used by the splitter toward each target
	modport master (input CLK, output we, re, addr, wdata, input rdata, err);

	// Splitter upstream side
	modport slave (input CLK, input we, re, addr, wdata, output rdata, err);

	// Register slave view, no error path
	modport target (input CLK, input we, re, addr, wdata, output rdata);

endinterface

// File: verilog/apb_reg_bridge.sv
// APB completer that issues register port strobes and returns the response
`timescale 1ns/1ps

module apb_reg_bridge (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  PSEL,
	input  logic                  PENABLE,
	input  logic                  PWRITE,
	input  regbus_pkg::reg_addr_t PADDR,
	input  regbus_pkg::reg_data_t PWDATA,
	output regbus_pkg::reg_data_t PRDATA,
	output logic                  PREADY,
	output logic                  PSLVERR,
	reg_port_if.master            bus
);
	// Idle waits for a setup phase, access covers both access cycles
	typedef enum logic {
		ph_idle,
		ph_access
	} phase_e;

	phase_e                phase_q;
	logic                  we_q;
	logic                  re_q;
	logic                  ready_q;
	logic                  setup;
	regbus_pkg::reg_addr_t addr_q;
	regbus_pkg::reg_data_t wdata_q;

	// Setup phase only counts while no transfer is in flight
	assign setup = PSEL & ~PENABLE & (phase_q == ph_idle);

	// --------------------
	// Phase and strobes
	// --------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase_q <= ph_idle;
			we_q    <= 1'b0;
			re_q    <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			// Strobe is high for access cycle 1 only
			we_q <= setup & PWRITE;
			re_q <= setup & ~PWRITE;
			case (phase_q)
				ph_idle: begin
					if (setup)
						phase_q <= ph_access;
				end
				ph_access: begin
					// Low in access 1, high in access 2, then back to idle
					ready_q <= ~ready_q;
					if (ready_q)
						phase_q <= ph_idle;
				end
				default: phase_q <= ph_idle;
			endcase
		end
	end

	// Address and write data held until the next setup phase
	always_ff @(posedge CLK) begin
		if (setup) begin
			addr_q  <= PADDR;
			wdata_q <= PWDATA;
		end
	end

	assign bus.we    = we_q;
	assign bus.re    = re_q;
	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;

	// Response only shown in access cycle 2
	assign PREADY  = ready_q;
	assign PSLVERR = ready_q & bus.err;
	assign PRDATA  = ready_q ? bus.rdata : '0;

	// --------------------
	// Checks
	// --------------------
	strobe_exclusive: assert property (@(posedge CLK) disable iff (reset)
		!(bus.we && bus.re))
		else $error("we and re high together");

endmodule

// File: verilog/reg_port_split.sv
// Register port decoder for the scratch and timer windows
`timescale 1ns/1ps
`include "regbus_params.svh"

module reg_port_split (
	reg_port_if.slave  up,
	reg_port_if.master scratch_port,
	reg_port_if.master timer_port
);
	localparam regbus_pkg::reg_addr_t scratch_limit =
		regbus_pkg::reg_addr_t'(`REGBUS_SCRATCH_WORDS * 4);
	localparam regbus_pkg::reg_addr_t timer_base = `REGBUS_TIMER_BASE;

	regbus_pkg::reg_sel_e sel;
	regbus_pkg::reg_sel_e sel_q;

	// Window decode, timer window is 16 bytes
	always_comb begin
		if (up.addr < scratch_limit)
			sel = regbus_pkg::sel_scratch;
		else if (up.addr[`REGBUS_ADDR_BITS-1:4] == timer_base[`REGBUS_ADDR_BITS-1:4])
			sel = regbus_pkg::sel_timer;
		else
			sel = regbus_pkg::sel_none;
	end

	// Unmapped strobes reach no target, so nothing changes
	assign up.err = (sel == regbus_pkg::sel_none);

	// --------------------
	// Qualified strobes
	// --------------------
	assign scratch_port.we    = up.we & (sel == regbus_pkg::sel_scratch);
	assign scratch_port.re    = up.re & (sel == regbus_pkg::sel_scratch);
	assign scratch_port.addr  = up.addr;
	assign scratch_port.wdata = up.wdata;

	assign timer_port.we    = up.we & (sel == regbus_pkg::sel_timer);
	assign timer_port.re    = up.re & (sel == regbus_pkg::sel_timer);
	assign timer_port.addr  = up.addr;
	assign timer_port.wdata = up.wdata;

	// Selection follows rdata by one cycle
	always_ff @(posedge up.CLK) begin
		sel_q <= sel;
	end

	always_comb begin
		case (sel_q)
			regbus_pkg::sel_scratch: up.rdata = scratch_port.rdata;
			regbus_pkg::sel_timer:   up.rdata = timer_port.rdata;
			default:                 up.rdata = '0;
		endcase
	end

	one_target: assert property (@(posedge up.CLK)
		$onehot0({scratch_port.we | scratch_port.re, timer_port.we | timer_port.re}))
		else $error("two targets strobed");

endmodule

// File: verilog/scratch_regs.sv
// Scratch bank of read/write register words
`timescale 1ns/1ps
`include "regbus_params.svh"

module scratch_regs (
	input logic        CLK,
	input logic        reset,
	reg_port_if.target bus
);
	localparam int word_bits = $clog2(`REGBUS_SCRATCH_WORDS);

	regbus_pkg::reg_data_t mem [`REGBUS_SCRATCH_WORDS];
	logic [word_bits-1:0]  word_idx;

	// Byte address to word index, low two bits ignored
	assign word_idx = bus.addr[word_bits+1:2];

	// --------------------
	// Storage
	// --------------------

	// Cleared on reset, one word written per we pulse
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `REGBUS_SCRATCH_WORDS; i++)
				mem[i] <= '0;
		end else if (bus.we) begin
			mem[word_idx] <= bus.wdata;
		end
	end

	// --------------------
	// Read port
	// --------------------

	// Registered on the re edge
	always_ff @(posedge CLK) begin
		if (reset)
			bus.rdata <= '0;
		else if (bus.re)
			bus.rdata <= mem[word_idx];
	end

endmodule

// File: verilog/compare_timer.sv
// Compare timer with control, compare, count, status registers and interrupt
`timescale 1ns/1ps
`include "regbus_params.svh"

module compare_timer (
	input  logic       CLK,
	input  logic       reset,
	reg_port_if.target bus,
	output logic       irq
);
	// CTRL bit 0 enable, bit 1 interrupt enable
	logic [1:0]            ctrl_q;
	regbus_pkg::reg_data_t compare_q;
	regbus_pkg::reg_data_t count_q;
	logic                  match_q;
	logic                  hit;
	logic                  status_clear;
	logic [3:0]            offs;

	assign offs = bus.addr[3:0];

	// Count meets compare while running
	assign hit = ctrl_q[0] & (count_q == compare_q);

	// Write one to clear
	assign status_clear = bus.we & (offs == `REGBUS_TIMER_STATUS) & bus.wdata[0];

	// --------------------
	// Registers
	// --------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			ctrl_q    <= '0;
			compare_q <= '0;
			count_q   <= '0;
			match_q   <= 1'b0;
			irq       <= 1'b0;
		end else begin
			if (bus.we && offs == `REGBUS_TIMER_CTRL)
				ctrl_q <= bus.wdata[1:0];
			if (bus.we && offs == `REGBUS_TIMER_COMPARE)
				compare_q <= bus.wdata;
			// COUNT is read-only, writes are dropped
			if (ctrl_q[0])
				count_q <= count_q + 32'd1;
			// A new hit wins over a clear in the same cycle
			match_q <= hit | (match_q & ~status_clear);
			irq     <= match_q & ctrl_q[1];
		end
	end

	// --------------------
	// Read port
	// --------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			bus.rdata <= '0;
		end else if (bus.re) begin
			case (offs)
				`REGBUS_TIMER_CTRL:    bus.rdata <= {30'd0, ctrl_q};
				`REGBUS_TIMER_COMPARE: bus.rdata <= compare_q;
				`REGBUS_TIMER_COUNT:   bus.rdata <= count_q;
				`REGBUS_TIMER_STATUS:  bus.rdata <= {31'd0, match_q};
				default:               bus.rdata <= '0;
			endcase
		end
	end

	// irq follows interrupt enable with one cycle of lag
	irq_needs_ie: assert property (@(posedge CLK) disable iff (reset)
		!ctrl_q[1] |=> !irq)
		else $error("irq high with interrupt enable clear");

endmodule

// File: verilog/regbus_top.sv
// Register subsystem top with APB completer port and timer interrupt
`timescale 1ns/1ps

module regbus_top (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  PSEL,
	input  logic                  PENABLE,
	input  logic                  PWRITE,
	input  regbus_pkg::reg_addr_t PADDR,
	input  regbus_pkg::reg_data_t PWDATA,
	output regbus_pkg::reg_data_t PRDATA,
	output logic                  PREADY,
	output logic                  PSLVERR,
	output logic                  irq
);
	// --------------------
	// Register ports
	// --------------------

	// Bridge to splitter
	reg_port_if host_bus (.CLK(CLK));
	// Splitter to each register slave
	reg_port_if scratch_bus (.CLK(CLK));
	reg_port_if timer_bus (.CLK(CLK));

	apb_reg_bridge bridge0 (
		.CLK     (CLK),
		.reset   (reset),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.bus     (host_bus)
	);

	reg_port_split split0 (
		.up           (host_bus),
		.scratch_port (scratch_bus),
		.timer_port   (timer_bus)
	);

	// Register slaves
	scratch_regs scratch0 (
		.CLK   (CLK),
		.reset (reset),
		.bus   (scratch_bus)
	);

	compare_timer timer0 (
		.CLK   (CLK),
		.reset (reset),
		.bus   (timer_bus),
		.irq   (irq)
	);

endmodule

// File: testbench/tb_regbus.sv
// Testbench for the register subsystem with APB driver tasks, LFSR data and assertion checks
`timescale 1ns/1ps
`include "regbus_params.svh"

module tb_regbus;
	// About 60 transfers of three cycles plus reset and the timer waits, with wide margin
	localparam int max_cycles = 2000;
	localparam regbus_pkg::reg_addr_t ctrl_addr = `REGBUS_TIMER_BASE + {8'h00, `REGBUS_TIMER_CTRL};
	localparam regbus_pkg::reg_addr_t cmp_addr = `REGBUS_TIMER_BASE + {8'h00, `REGBUS_TIMER_COMPARE};
	localparam regbus_pkg::reg_addr_t count_addr = `REGBUS_TIMER_BASE + {8'h00, `REGBUS_TIMER_COUNT};
	localparam regbus_pkg::reg_addr_t stat_addr = `REGBUS_TIMER_BASE + {8'h00, `REGBUS_TIMER_STATUS};

	logic                  CLK;
	logic                  reset;
	logic                  PSEL;
	logic                  PENABLE;
	logic                  PWRITE;
	regbus_pkg::reg_addr_t PADDR;
	regbus_pkg::reg_data_t PWDATA;
	regbus_pkg::reg_data_t PRDATA;
	logic                  PREADY;
	logic                  PSLVERR;
	logic                  irq;

	int                    value_errors = 0;
	int                    protocol_errors = 0;
	int                    cycle_count = 0;
	logic [31:0]           lfsr_state = 32'hd55f_c666;
	// Model of the scratch bank contents
	regbus_pkg::reg_data_t expect_mem [`REGBUS_SCRATCH_WORDS];

	regbus_top dut0 (
		.CLK     (CLK),
		.reset   (reset),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.irq     (irq)
	);

	// 4 ns period
	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// Watchdog
	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("Timeout, run did not finish within %0d cycles", max_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// --------------------
	// Protocol assertions
	// --------------------

	// Setup, access 1 with PREADY low, access 2 with PREADY high
	ready_timing: assert property (@(posedge CLK) disable iff (reset)
		(PSEL && !PENABLE) |=> (!PREADY ##1 PREADY))
		else begin
			protocol_errors++;
			$display("PREADY did not rise on the second access cycle");
		end

	ready_pulse: assert property (@(posedge CLK) disable iff (reset)
		PREADY |=> !PREADY)
		else begin
			protocol_errors++;
			$display("PREADY stayed high for more than one cycle");
		end

	// Outputs quiet straight after reset
	reset_quiet: assert property (@(posedge CLK)
		$fell(reset) |-> (!PREADY && !PSLVERR && !irq))
		else begin
			protocol_errors++;
			$display("PREADY, PSLVERR or irq high after reset");
		end

	// --------------------
	// Helpers
	// --------------------

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic random_word(output regbus_pkg::reg_data_t word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			word = {word[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		value_ok: assert (exp === act)
		else begin
			value_errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic apb_transfer(input string name, input logic write,
		input regbus_pkg::reg_addr_t addr, input regbus_pkg::reg_data_t wdata,
		input logic exp_err, output regbus_pkg::reg_data_t rdata);
		int access_cycle;
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = write;
		PADDR   = addr;
		PWDATA  = wdata;
		@(posedge CLK);
		#1;
		PENABLE      = 1'b1;
		access_cycle = 1;
		while (!PREADY) begin
			@(posedge CLK);
			#1;
			access_cycle++;
		end
		check_value({name, " access cycle"}, 32'd2, access_cycle);
		check_value({name, " PSLVERR"}, {31'd0, exp_err}, {31'd0, PSLVERR});
		rdata = PRDATA;
		// Hold the access phase through the completing edge
		@(posedge CLK);
		#1;
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic write_reg(input string name, input regbus_pkg::reg_addr_t addr,
		input regbus_pkg::reg_data_t data, input logic exp_err);
		regbus_pkg::reg_data_t discard;
		apb_transfer(name, 1'b1, addr, data, exp_err, discard);
	endtask

	task automatic read_reg(input string name, input regbus_pkg::reg_addr_t addr,
		output regbus_pkg::reg_data_t data);
		apb_transfer(name, 1'b0, addr, '0, 1'b0, data);
	endtask

	task automatic read_expect(input string name, input regbus_pkg::reg_addr_t addr,
		input regbus_pkg::reg_data_t exp, input logic exp_err);
		regbus_pkg::reg_data_t got;
		apb_transfer(name, 1'b0, addr, '0, exp_err, got);
		check_value(name, exp, got);
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin : main
		regbus_pkg::reg_data_t word;
		regbus_pkg::reg_data_t count_a;
		regbus_pkg::reg_data_t count_b;
		int                    stamp;
		int                    waited;
		logic                  irq_seen;
		reset   = 1'b1;
		PSEL    = 1'b0;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
		PADDR   = '0;
		PWDATA  = '0;
		repeat (16) @(posedge CLK);
		#1;
		reset = 1'b0;

		// Everything reads zero after reset
		for (int i = 0; i < `REGBUS_SCRATCH_WORDS; i++)
			read_expect("reset scratch", regbus_pkg::reg_addr_t'(i * 4), '0, 1'b0);
		read_expect("reset CTRL", ctrl_addr, '0, 1'b0);
		read_expect("reset COMPARE", cmp_addr, '0, 1'b0);
		read_expect("reset COUNT", count_addr, '0, 1'b0);
		read_expect("reset STATUS", stat_addr, '0, 1'b0);

		// Scratch fill, readback, then one word rewritten
		for (int i = 0; i < `REGBUS_SCRATCH_WORDS; i++) begin
			random_word(word);
			expect_mem[i] = word;
			write_reg("scratch write", regbus_pkg::reg_addr_t'(i * 4), word, 1'b0);
		end
		for (int i = 0; i < `REGBUS_SCRATCH_WORDS; i++)
			read_expect("scratch readback", regbus_pkg::reg_addr_t'(i * 4), expect_mem[i], 1'b0);
		random_word(word);
		expect_mem[3] = word;
		write_reg("scratch rewrite", 12'h00C, word, 1'b0);
		for (int i = 0; i < `REGBUS_SCRATCH_WORDS; i++)
			read_expect("scratch neighbors", regbus_pkg::reg_addr_t'(i * 4), expect_mem[i], 1'b0);

		// Unmapped holes, 0x080 aliases scratch word 0 in the low bits
		random_word(word);
		write_reg("unmapped write 080", 12'h080, word, 1'b1);
		read_expect("unmapped read 080", 12'h080, '0, 1'b1);
		write_reg("unmapped write 200", 12'h200, word, 1'b1);
		read_expect("unmapped read 200", 12'h200, '0, 1'b1);
		read_expect("scratch after unmapped", 12'h000, expect_mem[0], 1'b0);

		// Timer match with interrupt enabled
		write_reg("timer compare", cmp_addr, 32'd20, 1'b0);
		write_reg("timer enable", ctrl_addr, 32'd3, 1'b0);
		waited = 0;
		while (!irq && waited < 30) begin
			@(posedge CLK);
			#1;
			waited++;
		end
		check_value("irq rise", 32'd1, {31'd0, irq});
		read_expect("status after match", stat_addr, 32'd1, 1'b0);
		write_reg("status clear", stat_addr, 32'd1, 1'b0);
		check_value("irq after clear", 32'd0, {31'd0, irq});
		read_expect("status cleared", stat_addr, 32'd0, 1'b0);

		// New match with interrupt enable off, flag sets but irq stays low
		write_reg("timer no ie", ctrl_addr, 32'd1, 1'b0);
		read_reg("count snapshot", count_addr, count_a);
		write_reg("timer compare ahead", cmp_addr, count_a + 32'd30, 1'b0);
		irq_seen = 1'b0;
		repeat (40) begin
			@(posedge CLK);
			#1;
			irq_seen = irq_seen | irq;
		end
		check_value("irq masked", 32'd0, {31'd0, irq_seen});
		read_expect("status masked match", stat_addr, 32'd1, 1'b0);
		write_reg("status clear masked", stat_addr, 32'd1, 1'b0);

		// COUNT ignores writes and runs only while enabled
		read_reg("count first", count_addr, count_a);
		stamp = cycle_count;
		write_reg("count write", count_addr, '0, 1'b0);
		read_reg("count second", count_addr, count_b);
		count_running: assert (count_b >= count_a + 32'(cycle_count - stamp))
		else begin
			value_errors++;
			$display("Fail count running expected at least %0d actual %0d",
				count_a + 32'(cycle_count - stamp), count_b);
		end
		write_reg("timer disable", ctrl_addr, 32'd0, 1'b0);
		read_reg("count stopped first", count_addr, count_a);
		repeat (10) @(posedge CLK);
		#1;
		read_expect("count stopped", count_addr, count_a, 1'b0);

		$display("Checks done with %0d value errors and %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
verilog/regbus_pkg.sv
verilog/reg_port_if.sv
verilog/apb_reg_bridge.sv
verilog/reg_port_split.sv
verilog/scratch_regs.sv
verilog/compare_timer.sv
verilog/regbus_top.sv
testbench/tb_regbus.sv

// File: run_sim.sh
#!/bin/sh
# Build the register subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_regbus -o tb_regbus

# Exit status follows the closing report of the testbench
out=$(./obj_dir/tb_regbus)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"
